// ==== palette_pkg.sv ====
`default_nettype none

package palette_pkg;

	// ****************************************
	// Bus widths
	// ****************************************

	localparam int DATA_W = 8; // CPU data bus and palette register width.
	localparam int ADR_W = 8; // Low byte of the I/O address.
	localparam int PIX_W = 2; // Colour index and shade width.

	// ****************************************
	// Register map
	// ****************************************

	typedef enum logic [ADR_W-1:0] {
		REG_BGP = 8'h47, // Background palette at 0xFF47.
		REG_OBP0 = 8'h48, // Object palette 0 at 0xFF48.
		REG_OBP1 = 8'h49 // Object palette 1 at 0xFF49.
	} reg_offset_t;

	// Read value for an offset that holds no register.
	localparam logic [DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

	// ****************************************
	// Pixel palette select
	// ****************************************

	typedef enum logic [1:0] {
		PAL_BG = 2'd0,
		PAL_OBJ0 = 2'd1,
		PAL_OBJ1 = 2'd2
	} palette_sel_t;

endpackage

`default_nettype wire

// ==== io_decode.sv ====
`default_nettype none

module io_decode (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [palette_pkg::ADR_W-1:0] wb_adr,
	input wire logic [palette_pkg::DATA_W-1:0] wb_dat_w,
	output logic [palette_pkg::DATA_W-1:0] wb_dat_r,
	output logic wb_ack,

	output logic wr_bgp,
	output logic wr_obp0,
	output logic wr_obp1,
	output logic [palette_pkg::DATA_W-1:0] wr_data,

	input wire logic [palette_pkg::DATA_W-1:0] bgp,
	input wire logic [palette_pkg::DATA_W-1:0] obp0,
	input wire logic [palette_pkg::DATA_W-1:0] obp1
);

	logic req;
	logic [2:0] wr_sel;
	logic [palette_pkg::DATA_W-1:0] rd_sel;

	// A new request is one not already answered in this cycle.
	assign req = wb_cyc && wb_stb && !wb_ack;

	// ****************************************
	// Address decode
	// ****************************************

	always_comb begin
		rd_sel = palette_pkg::UNMAPPED_DATA;
		wr_sel = 3'b000;
		case (palette_pkg::reg_offset_t'(wb_adr))
			palette_pkg::REG_BGP: begin
				rd_sel = bgp;
				wr_sel = 3'b001;
			end
			palette_pkg::REG_OBP0: begin
				rd_sel = obp0;
				wr_sel = 3'b010;
			end
			palette_pkg::REG_OBP1: begin
				rd_sel = obp1;
				wr_sel = 3'b100;
			end
			default: begin
				// Unmapped offsets still get an ack below.
				rd_sel = palette_pkg::UNMAPPED_DATA;
				wr_sel = 3'b000;
			end
		endcase
	end

	// ****************************************
	// Ack and write strobes
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			wr_bgp <= 1'b0;
			wr_obp0 <= 1'b0;
			wr_obp1 <= 1'b0;
		end else begin
			wb_ack <= req; // High for the one cycle after the request.
			wr_bgp <= req && wb_we && wr_sel[0];
			wr_obp0 <= req && wb_we && wr_sel[1];
			wr_obp1 <= req && wb_we && wr_sel[2];
		end
	end

	// Payload registers for the bus data in both directions.
	always_ff @(posedge clk) begin
		if (req && wb_we) begin
			wr_data <= wb_dat_w; // Lines up with the write strobe.
		end
		if (req && !wb_we) begin
			wb_dat_r <= rd_sel; // Valid while wb_ack is high.
		end
	end

endmodule

`default_nettype wire

// ==== palettes.sv ====
`default_nettype none

module palettes (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic wr_bgp,
	input wire logic wr_obp0,
	input wire logic wr_obp1,
	input wire logic [palette_pkg::DATA_W-1:0] wr_data,

	output logic [palette_pkg::DATA_W-1:0] bgp,
	output logic [palette_pkg::DATA_W-1:0] obp0,
	output logic [palette_pkg::DATA_W-1:0] obp1
);

	logic [palette_pkg::DATA_W-1:0] bgp_q;
	logic [palette_pkg::DATA_W-1:0] obp0_q;
	logic [palette_pkg::DATA_W-1:0] obp1_q;

	// ****************************************
	// Background palette, 0xFF47
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bgp_q <= '0;
		end else if (wr_bgp) begin
			bgp_q <= wr_data; // Shade for index n sits in bits 2n+1 and 2n.
		end
	end

	// ****************************************
	// Object palette 0, 0xFF48
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			obp0_q <= '0;
		end else if (wr_obp0) begin
			obp0_q <= wr_data; // Bits 1 and 0 are stored though never drawn.
		end
	end

	// ****************************************
	// Object palette 1, 0xFF49
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			obp1_q <= '0;
		end else if (wr_obp1) begin
			obp1_q <= wr_data;
		end
	end

	// The stored values feed both the read mux and the pixel lookup.
	assign bgp = bgp_q;
	assign obp0 = obp0_q;
	assign obp1 = obp1_q;

endmodule

`default_nettype wire

// ==== pixel_shade.sv ====
`default_nettype none

module pixel_shade (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic pix_valid,
	input wire logic [palette_pkg::PIX_W-1:0] pix_index,
	input wire palette_pkg::palette_sel_t pix_palette,

	input wire logic [palette_pkg::DATA_W-1:0] bgp,
	input wire logic [palette_pkg::DATA_W-1:0] obp0,
	input wire logic [palette_pkg::DATA_W-1:0] obp1,

	output logic shade_valid,
	output logic [palette_pkg::PIX_W-1:0] shade,
	output logic shade_transparent
);

	logic [palette_pkg::DATA_W-1:0] pal_byte;
	logic is_obj;
	logic [palette_pkg::PIX_W-1:0] shade_d;
	logic transparent_d;

	// ****************************************
	// Palette select and lookup
	// ****************************************

	always_comb begin
		pal_byte = bgp;
		is_obj = 1'b0;
		case (pix_palette)
			palette_pkg::PAL_OBJ0: begin
				pal_byte = obp0;
				is_obj = 1'b1;
			end
			palette_pkg::PAL_OBJ1: begin
				pal_byte = obp1;
				is_obj = 1'b1;
			end
			default: begin
				pal_byte = bgp; // The unused select code falls back to background.
				is_obj = 1'b0;
			end
		endcase
	end

	// Index n picks bits 2n+1 down to 2n.
	assign shade_d = pal_byte[{pix_index, 1'b0} +: palette_pkg::PIX_W];

	// Object colour 0 is never drawn.
	assign transparent_d = is_obj && (pix_index == '0);

	// ****************************************
	// Output stage
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shade_valid <= 1'b0;
		end else begin
			shade_valid <= pix_valid; // One cycle after the input pixel.
		end
	end

	// Hold the last shade while no pixel arrives.
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			shade <= shade_d;
			shade_transparent <= transparent_d;
		end
	end

endmodule

`default_nettype wire

// ==== palette_unit.sv ====
`default_nettype none

module palette_unit (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [palette_pkg::ADR_W-1:0] wb_adr,
	input wire logic [palette_pkg::DATA_W-1:0] wb_dat_w,
	output logic [palette_pkg::DATA_W-1:0] wb_dat_r,
	output logic wb_ack,

	input wire logic pix_valid,
	input wire logic [palette_pkg::PIX_W-1:0] pix_index,
	input wire palette_pkg::palette_sel_t pix_palette,
	output logic shade_valid,
	output logic [palette_pkg::PIX_W-1:0] shade,
	output logic shade_transparent
);

	logic wr_bgp;
	logic wr_obp0;
	logic wr_obp1;
	logic [palette_pkg::DATA_W-1:0] wr_data;

	logic [palette_pkg::DATA_W-1:0] bgp;
	logic [palette_pkg::DATA_W-1:0] obp0;
	logic [palette_pkg::DATA_W-1:0] obp1;

	// ****************************************
	// CPU side
	// ****************************************

	io_decode u_io_decode (
		.clk (clk),
		.rst_n (rst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.wr_bgp (wr_bgp),
		.wr_obp0 (wr_obp0),
		.wr_obp1 (wr_obp1),
		.wr_data (wr_data),
		.bgp (bgp),
		.obp0 (obp0),
		.obp1 (obp1)
	);

	palettes u_palettes (
		.clk (clk),
		.rst_n (rst_n),
		.wr_bgp (wr_bgp),
		.wr_obp0 (wr_obp0),
		.wr_obp1 (wr_obp1),
		.wr_data (wr_data),
		.bgp (bgp),
		.obp0 (obp0),
		.obp1 (obp1)
	);

	// ****************************************
	// Pixel side
	// ****************************************

	pixel_shade u_pixel_shade (
		.clk (clk),
		.rst_n (rst_n),
		.pix_valid (pix_valid),
		.pix_index (pix_index),
		.pix_palette (pix_palette),
		.bgp (bgp), // Values before any write on the same edge.
		.obp0 (obp0),
		.obp1 (obp1),
		.shade_valid (shade_valid),
		.shade (shade),
		.shade_transparent (shade_transparent)
	);

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #5 clk = ~clk; // Period of 10 time units.

endmodule

`default_nettype wire

// ==== palette_unit_props.sv ====
`default_nettype none

module palette_unit_props (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic wr_bgp,
	input wire logic wr_obp0,
	input wire logic wr_obp1
);

	// ****************************************
	// Wishbone handshake
	// ****************************************

	ack_inside_request: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack is high without an active cycle and strobe.");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack is high in two consecutive cycles.");

	// A strobe only fires for the write being acknowledged.
	strobe_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_bgp || wr_obp0 || wr_obp1) |-> (wb_ack && $onehot({wr_bgp, wr_obp0, wr_obp1})))
		else $error("Write strobe without ack, or more than one strobe at once.");

endmodule

bind io_decode palette_unit_props u_props (
	.clk (clk),
	.rst_n (rst_n),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.wr_bgp (wr_bgp),
	.wr_obp0 (wr_obp0),
	.wr_obp1 (wr_obp1)
);

`default_nettype wire

// ==== palette_unit_tb.sv ====
`default_nettype none

module palette_unit_tb;

	localparam int NUM_TXN = 2000;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_WAIT_MAX = 4;
	localparam int CYCLE_LIMIT = NUM_TXN * 3 * 2 + RESET_CYCLES; // Three cycles worst case, doubled.

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [7:0] wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic wb_ack;
	logic pix_valid;
	logic [1:0] pix_index;
	palette_pkg::palette_sel_t pix_palette;
	logic shade_valid;
	logic [1:0] shade;
	logic shade_transparent;

	logic [31:0] rng;
	int error_count;
	int check_count;
	int cycle_count = 0;

	// ****************************************
	// Reference model state
	// ****************************************

	logic [7:0] m_bgp;
	logic [7:0] m_obp0;
	logic [7:0] m_obp1;
	logic [4:0] pix_q[$]; // {valid, seen, transparent, shade} for the next cycle.
	logic [1:0] last_shade;
	logic last_transp;
	logic shade_seen;
	logic exp_ack;

	logic bus_busy;
	logic bus_hold;
	logic bus_we;
	logic [7:0] bus_adr;
	logic [7:0] bus_dat;
	int bus_wait;
	int txn_started;
	int txn_done;
	logic wr_pending;
	logic [7:0] wr_adr;
	logic [7:0] wr_val;
	logic stim_on;

	tb_clock u_clock (
		.clk (clk)
	);

	palette_unit UUT (
		.clk (clk),
		.rst_n (rst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.pix_valid (pix_valid),
		.pix_index (pix_index),
		.pix_palette (pix_palette),
		.shade_valid (shade_valid),
		.shade (shade),
		.shade_transparent (shade_transparent)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] model_read(input logic [7:0] adr);
		case (adr)
			palette_pkg::REG_BGP: return m_bgp;
			palette_pkg::REG_OBP0: return m_obp0;
			palette_pkg::REG_OBP1: return m_obp1;
			default: return palette_pkg::UNMAPPED_DATA;
		endcase
	endfunction

	function automatic logic [1:0] model_shade(input palette_pkg::palette_sel_t pal,
		input logic [1:0] idx);
		logic [7:0] pal_byte;
		case (pal)
			palette_pkg::PAL_OBJ0: pal_byte = m_obp0;
			palette_pkg::PAL_OBJ1: pal_byte = m_obp1;
			default: pal_byte = m_bgp;
		endcase
		return 2'((pal_byte >> (2 * idx)) & 8'h03);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic [4:0] e;
		compare_value("wb_ack", 32'(wb_ack), 32'(exp_ack));
		if (pix_q.size() > 0) begin
			e = pix_q.pop_front();
			compare_value("shade_valid", 32'(shade_valid), 32'(e[4]));
			if (e[4] || e[3]) begin // Idle cycles hold the last pixel.
				compare_value("shade", 32'(shade), 32'(e[1:0]));
				compare_value("shade_transparent", 32'(shade_transparent), 32'(e[2]));
			end
		end
	endtask

	task automatic start_transaction();
		rng = xorshift32(rng);
		if (txn_started < 3) begin
			bus_we = 1'b0; // Reset values of all three registers come first.
			bus_adr = 8'h47 + 8'(txn_started);
		end else begin
			bus_we = rng[0];
			if (rng[15:8] % 8'd5 == 8'd0) begin
				bus_adr = rng[23:16];
				if (bus_adr >= 8'h47 && bus_adr <= 8'h49) begin
					bus_adr = bus_adr ^ 8'h80;
				end
			end else begin
				bus_adr = 8'h47 + (rng[23:16] % 8'd3);
			end
		end
		bus_dat = rng[31:24];
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = bus_we;
		wb_adr = bus_adr;
		wb_dat_w = bus_dat;
		bus_busy = 1'b1;
		bus_wait = 0;
		txn_started++;
	endtask

	task automatic bus_step();
		wr_pending = 1'b0;
		if (bus_hold) begin
			bus_hold = 1'b0; // The ack cycle has ended.
			bus_busy = 1'b0;
		end else if (bus_busy) begin
			if (wb_ack) begin
				if (bus_we) begin
					wr_pending = 1'b1;
					wr_adr = bus_adr;
					wr_val = bus_dat;
				end else begin
					compare_value("wb_dat_r", 32'(wb_dat_r), 32'(model_read(bus_adr)));
				end
				bus_hold = 1'b1;
				txn_done++;
			end else if (bus_wait >= ACK_WAIT_MAX) begin
				error_count++;
				$display("No ack within %0d cycles for the access to offset 0x%02h.",
					ACK_WAIT_MAX, bus_adr);
				bus_busy = 1'b0;
				txn_done++;
			end else begin
				bus_wait++;
			end
		end
		if (!bus_busy && stim_on && txn_started < NUM_TXN) begin
			rng = xorshift32(rng);
			if (rng[1:0] != 2'b00 || txn_started < 3) begin
				start_transaction();
			end
		end
		if (!bus_busy) begin
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
		end
	endtask

	task automatic pixel_step();
		palette_pkg::palette_sel_t pal;
		logic [1:0] idx;
		logic valid;
		rng = xorshift32(rng);
		valid = stim_on && (rng[2:0] != 3'b000);
		idx = rng[5:4];
		case (rng[15:8] % 8'd3)
			8'd0: pal = palette_pkg::PAL_BG;
			8'd1: pal = palette_pkg::PAL_OBJ0;
			default: pal = palette_pkg::PAL_OBJ1;
		endcase
		pix_valid = valid;
		pix_index = idx;
		pix_palette = pal;
		if (valid) begin
			last_shade = model_shade(pal, idx); // Registers before this cycle's write.
			last_transp = (pal != palette_pkg::PAL_BG) && (idx == 2'd0);
			shade_seen = 1'b1;
		end
		pix_q.push_back({valid, shade_seen, last_transp, last_shade});
	endtask

	task automatic apply_write();
		if (wr_pending) begin
			case (wr_adr)
				palette_pkg::REG_BGP: m_bgp = wr_val;
				palette_pkg::REG_OBP0: m_obp0 = wr_val;
				palette_pkg::REG_OBP1: m_obp1 = wr_val;
				default: begin
				end
			endcase
		end
	endtask

	task automatic step_cycle();
		@(negedge clk);
		check_outputs();
		bus_step();
		pixel_step();
		apply_write();
		exp_ack = bus_busy && !bus_hold && (bus_wait == 0); // Due the cycle after a new strobe.
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 8'h00;
		wb_dat_w = 8'h00;
		pix_valid = 1'b0;
		pix_index = 2'd0;
		pix_palette = palette_pkg::PAL_BG;
		rng = 32'd35564;
		error_count = 0;
		check_count = 0;
		m_bgp = 8'h00;
		m_obp0 = 8'h00;
		m_obp1 = 8'h00;
		last_shade = 2'd0;
		last_transp = 1'b0;
		shade_seen = 1'b0;
		exp_ack = 1'b0;
		bus_busy = 1'b0;
		bus_hold = 1'b0;
		bus_we = 1'b0;
		bus_adr = 8'h00;
		bus_dat = 8'h00;
		bus_wait = 0;
		txn_started = 0;
		txn_done = 0;
		wr_pending = 1'b0;
		wr_adr = 8'h00;
		wr_val = 8'h00;
		stim_on = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (4) step_cycle(); // Quiet outputs before stimulus.
		stim_on = 1'b1;
		while (txn_done < NUM_TXN) begin
			step_cycle();
		end
		stim_on = 1'b0;
		repeat (3) step_cycle();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d of %0d bus transactions done.",
				cycle_count, txn_done, NUM_TXN);
			$display("Regression failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
palette_pkg.sv
io_decode.sv
palettes.sv
pixel_shade.sv
palette_unit.sv
tb_clock.sv
palette_unit_props.sv
palette_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module palette_unit_tb \
	-f all.f -o palette_unit_sim

status=0
./obj_dir/palette_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
	echo "Simulation reported a failure, see sim.log."
	exit 1
fi

echo "Simulation finished without failure."
